/* Bender.yml */
package:
  name: ooo_core

sources:
  - files:
      - core_cfg_pkg.sv
      - isa_pkg.sv
      - core_if.sv
      - rename_stage.sv
      - phys_regfile.sv
      - issue_queue.sv
      - alu_exec.sv
      - reorder_buffer.sv
      - ooo_core.sv
  - target: test
    files:
      - tb_ooo_core_sva.sv
      - tb_ooo_core.sv

/* alu_exec.sv */
module alu_exec (
    input  logic    clk,
    input  logic    reset,
    issue_if.sink   iss,
    cdb_if.source   cdb
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    xlen_t result;

    always_comb begin
        case (iss.op)
            alu_sub: result = iss.a - iss.b;
            alu_and: result = iss.a & iss.b;
            alu_or:  result = iss.a | iss.b;
            alu_xor: result = iss.a ^ iss.b;
            // Shift amount is the low 5 bits of b
            alu_sll: result = iss.a << iss.b[$clog2(xlen)-1:0];
            alu_srl: result = iss.a >> iss.b[$clog2(xlen)-1:0];
            alu_slt: result = xlen_t'($signed(iss.a) < $signed(iss.b));
            default: result = iss.a + iss.b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= iss.valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb.tag     <= iss.dst;
        cdb.value   <= result;
        cdb.rob_idx <= iss.rob_idx;
    end

endmodule

/* core_cfg_pkg.sv */
package core_cfg_pkg;

    // Machine sizes
    localparam int xlen          = 32;
    localparam int num_arch_regs = 32;
    localparam int num_phys_regs = 64;
    localparam int free_depth    = num_phys_regs - num_arch_regs;
    localparam int rob_depth     = 16;
    localparam int iq_depth      = 4;

    // Data word and register numbers
    typedef logic [xlen-1:0]                  xlen_t;
    typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;
    typedef logic [$clog2(num_phys_regs)-1:0] phys_reg_t;

    // Queue indices and counts
    typedef logic [$clog2(rob_depth)-1:0]     rob_idx_t;
    typedef logic [$clog2(rob_depth+1)-1:0]   rob_cnt_t;
    typedef logic [$clog2(free_depth)-1:0]    free_ptr_t;
    typedef logic [$clog2(iq_depth)-1:0]      iq_slot_t;

endpackage

/* core_if.sv */
// Renamed operation, rename stage to issue queue
interface rename_if (input logic clk);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    logic      valid;
    alu_op_e   op;
    phys_reg_t src1;
    phys_reg_t src2;
    phys_reg_t dst;
    logic      use_imm;
    xlen_t     imm;
    rob_idx_t  rob_idx;

    modport source (input clk, output valid, op, src1, src2, dst, use_imm, imm, rob_idx);
    modport sink (input clk, valid, op, src1, src2, dst, use_imm, imm, rob_idx);
    modport monitor (input clk, valid, src1, src2, dst);
endinterface

interface rob_alloc_if (input logic clk);
    import core_cfg_pkg::*;

    logic      valid;
    arch_reg_t rd;
    logic      writes;
    phys_reg_t dst;
    phys_reg_t old_dst;
    rob_idx_t  idx;
    logic      space_ok;

    modport rename (input clk, idx, space_ok, output valid, rd, writes, dst, old_dst);
    modport rob (input clk, valid, rd, writes, dst, old_dst, output idx, space_ok);
endinterface

interface issue_if (input logic clk);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    logic      valid;
    alu_op_e   op;
    xlen_t     a;
    xlen_t     b;
    phys_reg_t dst;
    rob_idx_t  rob_idx;

    modport source (input clk, output valid, op, a, b, dst, rob_idx);
    modport sink (input clk, valid, op, a, b, dst, rob_idx);
endinterface

// Result bus, single source
interface cdb_if (input logic clk);
    import core_cfg_pkg::*;

    logic      valid;
    phys_reg_t tag;
    xlen_t     value;
    rob_idx_t  rob_idx;

    modport source (input clk, output valid, tag, value, rob_idx);
    modport sink (input clk, valid, tag, value, rob_idx);
endinterface

/* files.f */
core_cfg_pkg.sv
isa_pkg.sv
core_if.sv
rename_stage.sv
phys_regfile.sv
issue_queue.sv
alu_exec.sv
reorder_buffer.sv
ooo_core.sv
tb_ooo_core_sva.sv
tb_ooo_core.sv

/* isa_pkg.sv */
package isa_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Field layout, opcode on top
    localparam int opcode_lsb = 26;
    localparam int rd_lsb     = 21;
    localparam int rs1_lsb    = 16;
    localparam int rs2_lsb    = 11;
    localparam int imm_w      = 16;

    // Major opcodes
    localparam opcode_t op_alu  = 6'h00;
    localparam opcode_t op_addi = 6'h08;

    // Function codes of the register form
    localparam funct_t fn_add = 6'h20;
    localparam funct_t fn_sub = 6'h22;
    localparam funct_t fn_and = 6'h24;
    localparam funct_t fn_or  = 6'h25;
    localparam funct_t fn_xor = 6'h26;
    localparam funct_t fn_sll = 6'h00;
    localparam funct_t fn_srl = 6'h02;
    localparam funct_t fn_slt = 6'h2a;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_slt
    } alu_op_e;

endpackage

/* issue_queue.sv */
module issue_queue (
    input  logic                clk,
    input  logic                reset,
    rename_if.sink              ren,
    input  logic                src1_ready,
    input  core_cfg_pkg::xlen_t src1_data,
    input  logic                src2_ready,
    input  core_cfg_pkg::xlen_t src2_data,
    cdb_if.sink                 cdb,
    issue_if.source             iss,
    output logic                iq_space_ok
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    logic [iq_depth-1:0] busy, rdy1, rdy2;
    alu_op_e             op_q [iq_depth];
    xlen_t               a_q [iq_depth];
    xlen_t               b_q [iq_depth];
    phys_reg_t           tag1_q [iq_depth];
    phys_reg_t           tag2_q [iq_depth];
    phys_reg_t           dst_q [iq_depth];
    rob_idx_t            rob_q [iq_depth];
    iq_slot_t            alloc_slot, issue_slot;
    logic                issue_found;

    assign iq_space_ok = ($countones(~busy) >= 2);

    // Lowest free slot and lowest ready entry
    always_comb begin
        alloc_slot  = '0;
        issue_slot  = '0;
        issue_found = 1'b0;
        for (int i = iq_depth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_slot = iq_slot_t'(i);
            end
            if (busy[i] && rdy1[i] && rdy2[i]) begin
                issue_slot  = iq_slot_t'(i);
                issue_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= '0;
            iss.valid <= 1'b0;
        end else begin
            // Wakeup from the result bus
            for (int i = 0; i < iq_depth; i++) begin
                if (cdb.valid && busy[i] && !rdy1[i] && (tag1_q[i] == cdb.tag)) begin
                    a_q[i]  <= cdb.value;
                    rdy1[i] <= 1'b1;
                end
                if (cdb.valid && busy[i] && !rdy2[i] && (tag2_q[i] == cdb.tag)) begin
                    b_q[i]  <= cdb.value;
                    rdy2[i] <= 1'b1;
                end
            end
            iss.valid <= issue_found;
            if (issue_found) begin
                iss.op           <= op_q[issue_slot];
                iss.a            <= a_q[issue_slot];
                iss.b            <= b_q[issue_slot];
                iss.dst          <= dst_q[issue_slot];
                iss.rob_idx      <= rob_q[issue_slot];
                busy[issue_slot] <= 1'b0;
            end
            if (ren.valid) begin
                busy[alloc_slot]   <= 1'b1;
                op_q[alloc_slot]   <= ren.op;
                tag1_q[alloc_slot] <= ren.src1;
                tag2_q[alloc_slot] <= ren.src2;
                a_q[alloc_slot]    <= src1_data;
                rdy1[alloc_slot]   <= src1_ready;
                b_q[alloc_slot]    <= ren.use_imm ? ren.imm : src2_data;
                rdy2[alloc_slot]   <= ren.use_imm || src2_ready;
                dst_q[alloc_slot]  <= ren.dst;
                rob_q[alloc_slot]  <= ren.rob_idx;
            end
        end
    end

endmodule

/* ooo_core.sv */
module ooo_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  core_cfg_pkg::xlen_t     instr,
    output logic                    core_ready,
    output logic                    commit_valid,
    output core_cfg_pkg::arch_reg_t commit_rd,
    output logic                    commit_writes,
    output core_cfg_pkg::xlen_t     commit_value
);
    import core_cfg_pkg::*;

    logic      iq_space_ok, free_valid;
    phys_reg_t free_tag, commit_tag;
    xlen_t     commit_data, src1_data, src2_data;
    logic      src1_ready, src2_ready;

    rename_if    ren_bus (.clk(clk));
    rob_alloc_if alloc_bus (.clk(clk));
    issue_if     iss_bus (.clk(clk));
    cdb_if       cdb_bus (.clk(clk));

    // ==========================================================
    // Rename and dispatch
    // ==========================================================
    rename_stage rename_inst (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .core_ready(core_ready), .iq_space_ok(iq_space_ok), .free_valid(free_valid),
        .free_tag(free_tag), .ren(ren_bus), .alloc(alloc_bus)
    );

    phys_regfile prf_inst (
        .clk(clk), .reset(reset), .ren(ren_bus), .cdb(cdb_bus),
        .src1_ready(src1_ready), .src2_ready(src2_ready), .src1_data(src1_data),
        .src2_data(src2_data), .commit_tag(commit_tag), .commit_data(commit_data)
    );

    // ==========================================================
    // Issue, execute and commit
    // ==========================================================
    issue_queue iq_inst (
        .clk(clk), .reset(reset), .ren(ren_bus), .src1_ready(src1_ready),
        .src1_data(src1_data), .src2_ready(src2_ready), .src2_data(src2_data),
        .cdb(cdb_bus), .iss(iss_bus), .iq_space_ok(iq_space_ok)
    );

    alu_exec alu_inst (.clk(clk), .reset(reset), .iss(iss_bus), .cdb(cdb_bus));

    reorder_buffer rob_inst (
        .clk(clk), .reset(reset), .alloc(alloc_bus), .cdb(cdb_bus),
        .commit_tag(commit_tag), .commit_data(commit_data), .free_valid(free_valid),
        .free_tag(free_tag), .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_writes(commit_writes), .commit_value(commit_value)
    );

endmodule

/* phys_regfile.sv */
module phys_regfile (
    input  logic                    clk,
    input  logic                    reset,
    rename_if.monitor               ren,
    cdb_if.sink                     cdb,
    output logic                    src1_ready,
    output logic                    src2_ready,
    output core_cfg_pkg::xlen_t     src1_data,
    output core_cfg_pkg::xlen_t     src2_data,
    input  core_cfg_pkg::phys_reg_t commit_tag,
    output core_cfg_pkg::xlen_t     commit_data
);
    import core_cfg_pkg::*;

    xlen_t                    regs [num_phys_regs];
    logic [num_phys_regs-1:0] ready;
    logic                     cdb_wr, hit1, hit2;

    // Tag 0 is never written
    assign cdb_wr = cdb.valid && (cdb.tag != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= '1;
            for (int i = 0; i < num_phys_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ren.valid && (ren.dst != '0)) begin
                ready[ren.dst] <= 1'b0;
            end
            if (cdb_wr) begin
                regs[cdb.tag]  <= cdb.value;
                ready[cdb.tag] <= 1'b1;
            end
        end
    end

    // Same-cycle result bypass
    assign hit1       = cdb_wr && (cdb.tag == ren.src1);
    assign hit2       = cdb_wr && (cdb.tag == ren.src2);
    assign src1_ready = ready[ren.src1] || hit1;
    assign src2_ready = ready[ren.src2] || hit2;
    assign src1_data  = hit1 ? cdb.value : regs[ren.src1];
    assign src2_data  = hit2 ? cdb.value : regs[ren.src2];
    assign commit_data = regs[commit_tag];

endmodule

/* rename_stage.sv */
module rename_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  core_cfg_pkg::xlen_t   instr,
    output logic                  core_ready,
    input  logic                  iq_space_ok,
    input  logic                  free_valid,
    input  core_cfg_pkg::phys_reg_t free_tag,
    rename_if.source              ren,
    rob_alloc_if.rename           alloc
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    phys_reg_t map_table [num_arch_regs];
    phys_reg_t free_fifo [free_depth];
    free_ptr_t free_rd, free_wr;
    opcode_t   opcode;
    funct_t    funct;
    arch_reg_t rd, rs1, rs2;
    alu_op_e   op;
    logic      known, writes, accept;
    phys_reg_t new_dst;

    // ==========================================================
    // Decode
    // ==========================================================
    assign opcode = instr[opcode_lsb +: $bits(opcode_t)];
    assign rd     = instr[rd_lsb +: $bits(arch_reg_t)];
    assign rs1    = instr[rs1_lsb +: $bits(arch_reg_t)];
    assign rs2    = instr[rs2_lsb +: $bits(arch_reg_t)];
    assign funct  = instr[$bits(funct_t)-1:0];

    always_comb begin
        op    = alu_add;
        known = (opcode == op_addi);
        if (opcode == op_alu) begin
            known = 1'b1;
            case (funct)
                fn_add:  op = alu_add;
                fn_sub:  op = alu_sub;
                fn_and:  op = alu_and;
                fn_or:   op = alu_or;
                fn_xor:  op = alu_xor;
                fn_sll:  op = alu_sll;
                fn_srl:  op = alu_srl;
                fn_slt:  op = alu_slt;
                default: known = 1'b0;
            endcase
        end
    end

    // No-ops and x0 targets keep tag 0
    assign writes     = known && (rd != '0);
    assign new_dst    = writes ? free_fifo[free_rd] : '0;
    assign core_ready = iq_space_ok && alloc.space_ok;
    assign accept     = instr_valid && core_ready;

    // ==========================================================
    // Map table and free list
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            ren.valid   <= 1'b0;
            alloc.valid <= 1'b0;
            free_rd     <= '0;
            free_wr     <= '0;
            for (int i = 0; i < num_arch_regs; i++) begin
                map_table[i] <= phys_reg_t'(i);
            end
            for (int i = 0; i < free_depth; i++) begin
                free_fifo[i] <= phys_reg_t'(num_arch_regs + i);
            end
        end else begin
            ren.valid   <= accept;
            alloc.valid <= accept;
            if (accept && writes) begin
                map_table[rd] <= new_dst;
                free_rd       <= free_rd + 1'b1;
            end
            // Tags come back from commit
            if (free_valid) begin
                free_fifo[free_wr] <= free_tag;
                free_wr            <= free_wr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ren.op        <= op;
            ren.src1      <= map_table[rs1];
            ren.src2      <= map_table[rs2];
            ren.dst       <= new_dst;
            ren.use_imm   <= (opcode == op_addi);
            ren.imm       <= {{(xlen - imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
            ren.rob_idx   <= alloc.idx;
            alloc.rd      <= rd;
            alloc.writes  <= writes;
            alloc.dst     <= new_dst;
            alloc.old_dst <= map_table[rd];
        end
    end

endmodule

/* reorder_buffer.sv */
module reorder_buffer (
    input  logic                    clk,
    input  logic                    reset,
    rob_alloc_if.rob                alloc,
    cdb_if.sink                     cdb,
    output core_cfg_pkg::phys_reg_t commit_tag,
    input  core_cfg_pkg::xlen_t     commit_data,
    output logic                    free_valid,
    output core_cfg_pkg::phys_reg_t free_tag,
    output logic                    commit_valid,
    output core_cfg_pkg::arch_reg_t commit_rd,
    output logic                    commit_writes,
    output core_cfg_pkg::xlen_t     commit_value
);
    import core_cfg_pkg::*;

    arch_reg_t            rd_q [rob_depth];
    phys_reg_t            dst_q [rob_depth];
    phys_reg_t            old_q [rob_depth];
    logic [rob_depth-1:0] wr_q, done;
    rob_idx_t             head, tail;
    rob_cnt_t             count;
    logic                 retire;

    assign retire     = (count != '0) && done[head];
    assign commit_tag = dst_q[head];
    assign alloc.space_ok = (count <= rob_cnt_t'(rob_depth - 2));
    // Next tail, counting the allocation now in flight
    assign alloc.idx  = tail + rob_idx_t'(alloc.valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            commit_valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            commit_valid <= retire;
            free_valid   <= retire && wr_q[head];
            if (cdb.valid) begin
                done[cdb.rob_idx] <= 1'b1;
            end
            if (alloc.valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + rob_cnt_t'(alloc.valid) - rob_cnt_t'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            rd_q[tail]  <= alloc.rd;
            wr_q[tail]  <= alloc.writes;
            dst_q[tail] <= alloc.dst;
            old_q[tail] <= alloc.old_dst;
        end
        if (retire) begin
            commit_rd     <= rd_q[head];
            commit_writes <= wr_q[head];
            commit_value  <= commit_data;
            free_tag      <= old_q[head];
        end
    end

endmodule

/* tb_ooo_core.sv */
module tb_ooo_core;
    timeunit 1ns;
    timeprecision 1ps;
    import core_cfg_pkg::*;
    import isa_pkg::*;

    localparam int num_instr     = 2000;
    localparam int num_directed  = 4;
    localparam int chain_len     = 40;
    localparam int num_random    = num_instr - num_directed - chain_len;
    localparam int timeout_limit = num_instr * 8 + 200;

    logic      clk, reset, instr_valid, core_ready;
    xlen_t     instr;
    logic      commit_valid, commit_writes;
    arch_reg_t commit_rd;
    xlen_t     commit_value;

    int        seed = 32'h93308f38;
    int        sent = 0;
    int        commits = 0;
    int        cycles = 0;
    int        stall_cycles = 0;
    int        chain_stalls = 0;
    xlen_t     arch_regs [num_arch_regs];
    arch_reg_t exp_rd [$];
    logic      exp_wr [$];
    xlen_t     exp_val [$];

    ooo_core dut_i (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .core_ready(core_ready), .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_writes(commit_writes), .commit_value(commit_value)
    );

    always #20 clk = ~clk;

    // ==========================================================
    // Failure handling and compare tasks
    // ==========================================================
    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_reg(input string name, input arch_reg_t got, input arch_reg_t exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t %s got %h expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t %s got %b expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // ==========================================================
    // Instruction encoding and random program
    // ==========================================================
    function automatic xlen_t enc_alu(arch_reg_t rd, arch_reg_t rs1, arch_reg_t rs2,
                                      funct_t fn);
        return {op_alu, rd, rs1, rs2, 5'b0, fn};
    endfunction

    function automatic xlen_t enc_addi(arch_reg_t rd, arch_reg_t rs1, logic [15:0] imm);
        return {op_addi, rd, rs1, imm};
    endfunction

    // Mostly the low eight registers so that chains form often
    function automatic arch_reg_t pick_reg();
        if ($unsigned($random(seed)) % 4 != 0) begin
            return arch_reg_t'($unsigned($random(seed)) % 8);
        end
        return arch_reg_t'($random(seed));
    endfunction

    function automatic xlen_t random_instr();
        int unsigned kind;
        funct_t      fns [8] = '{fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_sll, fn_srl, fn_slt};
        kind = $unsigned($random(seed)) % 16;
        if (kind < 9) begin
            return enc_alu(pick_reg(), pick_reg(), pick_reg(), fns[$unsigned($random(seed)) % 8]);
        end
        if (kind < 14) begin
            return enc_addi(pick_reg(), pick_reg(), 16'($random(seed)));
        end
        // Unknown function code or unknown opcode
        if (kind == 14) begin
            return enc_alu(pick_reg(), pick_reg(), pick_reg(), 6'h3f);
        end
        return {6'h3e, 26'($random(seed))};
    endfunction

    // ==========================================================
    // Architectural model run in program order at acceptance
    // ==========================================================
    task automatic model_exec(input xlen_t w);
        opcode_t   opc;
        funct_t    fn;
        arch_reg_t rd, rs1, rs2;
        xlen_t     a, b, res;
        logic      known;
        opc   = w[31:26];
        rd    = w[25:21];
        rs1   = w[20:16];
        rs2   = w[15:11];
        fn    = w[5:0];
        a     = arch_regs[rs1];
        b     = (opc == op_addi) ? {{16{w[15]}}, w[15:0]} : arch_regs[rs2];
        known = 1'b1;
        res   = '0;
        if (opc == op_addi) begin
            res = a + b;
        end else if (opc == op_alu) begin
            case (fn)
                fn_add:  res = a + b;
                fn_sub:  res = a - b;
                fn_and:  res = a & b;
                fn_or:   res = a | b;
                fn_xor:  res = a ^ b;
                fn_sll:  res = a << b[4:0];
                fn_srl:  res = a >> b[4:0];
                fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: known = 1'b0;
            endcase
        end else begin
            known = 1'b0;
        end
        if (known && rd != 0) begin
            arch_regs[rd] = res;
        end
        exp_rd.push_back(rd);
        exp_wr.push_back(known && rd != 0);
        exp_val.push_back(res);
    endtask

    // Called just after a rising edge when core_ready is already stable
    task automatic send_instr(input xlen_t word);
        logic taken;
        instr       = word;
        instr_valid = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            taken = core_ready;
            if (!core_ready) begin
                stall_cycles++;
            end
            @(posedge clk);
            #2;
        end
        model_exec(word);
        sent++;
    endtask

    task automatic check_commit();
        arch_reg_t rd;
        logic      wr;
        xlen_t     val;
        if (exp_rd.size() == 0) begin
            $display("ERROR: a commit at time %0t has no outstanding instruction", $time);
            stop_on_failure();
        end else begin
            rd  = exp_rd.pop_front();
            wr  = exp_wr.pop_front();
            val = exp_val.pop_front();
            check_reg("commit_rd", commit_rd, rd);
            check_flag("commit_writes", commit_writes, wr);
            if (wr) begin
                check_data("commit_value", commit_value, val);
            end
            commits++;
        end
    endtask

    // Commit outputs are stable at the falling edge
    always @(negedge clk) begin
        if (dut_i.rob_inst.rob_sva_i.errors != 0) begin
            $display("ERROR: a reorder buffer assertion failed at time %0t", $time);
            stop_on_failure();
        end else if (!reset && commit_valid) begin
            check_commit();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("ERROR: timeout after %0d cycles, %0d of %0d retired", cycles, commits, sent);
            stop_on_failure();
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < num_arch_regs; i++) begin
            arch_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        check_flag("commit_valid", commit_valid, 1'b0);
        check_flag("core_ready", core_ready, 1'b1);

        // Negative immediate, write to x0, read of x0, unknown opcode
        send_instr(enc_addi(5'd1, 5'd0, 16'hfff3));
        send_instr(enc_addi(5'd0, 5'd1, 16'h0007));
        send_instr(enc_alu(5'd2, 5'd0, 5'd1, fn_sub));
        send_instr({6'h3e, 5'd5, 21'd0});

        // Dependent chain on x3 with instr_valid held high
        chain_stalls = stall_cycles;
        for (int i = 0; i < chain_len; i++) begin
            if (i % 2 == 0) begin
                send_instr(enc_alu(5'd3, 5'd3, 5'd4, fn_add));
            end else begin
                send_instr(enc_addi(5'd3, 5'd3, 16'(-i)));
            end
        end
        chain_stalls = stall_cycles - chain_stalls;

        for (int i = 0; i < num_random; i++) begin
            send_instr(random_instr());
        end
        instr_valid = 1'b0;

        while (commits != sent) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (chain_stalls > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("ERROR: core_ready never went low during the dependent chain");
            stop_on_failure();
        end
    end

endmodule

/* tb_ooo_core_sva.sv */
module rob_sva (
    input logic                   clk,
    input logic                   reset,
    input core_cfg_pkg::rob_cnt_t count,
    input logic                   space_ok,
    input logic                   alloc_valid,
    input logic                   commit_valid
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_cfg_pkg::*;

    int errors = 0;

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= rob_cnt_t'(rob_depth))
        else begin
            $error("ROB count above its depth");
            errors++;
        end

    quiet_after_reset: assert property (@(posedge clk) reset |=> !commit_valid)
        else begin
            $error("commit_valid high right after reset");
            errors++;
        end

    // Allocation follows acceptance by one cycle
    no_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
        !space_ok |=> !alloc_valid)
        else begin
            $error("ROB entry allocated without space");
            errors++;
        end

endmodule

bind reorder_buffer rob_sva rob_sva_i (
    .clk(clk), .reset(reset), .count(count), .space_ok(alloc.space_ok),
    .alloc_valid(alloc.valid), .commit_valid(commit_valid)
);
